// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --Mdir obj_dir
TOP = mem_tb
FILELIST = build.f

BIN = obj_dir/V$(TOP)
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/pipe_pkg.sv
verilog/data_ram.sv
verilog/load_store_unit.sv
verilog/memory_stage.sv
verilog/mem_subsystem.sv
verification/mem_checker.sv
verification/mem_tb.sv

// ==== verification/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_checker
(
	input wire logic clk,
	input wire logic reset,
	input wire pipe_pkg::ex_mem_t ex_mem_in,
	input wire logic [`DATA_W-1:0] dbg_addr,
	input wire pipe_pkg::mem_wb_t mem_wb_out,
	input wire logic pc_src,
	input wire logic [`DATA_W-1:0] pc_branch,
	input wire logic [`DATA_W-1:0] dbg_data,
	output logic busy,
	output int check_count,
	output int mismatch_count
);

	import pipe_pkg::*;

	// Copy of the EX/MEM register, one edge behind the input
	ex_mem_t stage_in;
	mem_wb_t expect_wb;
	logic expect_busy;
	logic expect_taken;

	// Shadow of the 16 words the stimulus touches
	logic [`DATA_W-1:0] shadow [0:15];
	logic [15:0] shadow_known;

	int checks = 0;
	int mismatches = 0;

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////

	// sh and sb write a whole sign-extended word
	function automatic logic [31:0] stored_word(input ex_mem_t t);
		logic [31:0] half_sx;
		logic [31:0] byte_sx;
		half_sx = 32'($signed(t.store_data[15:0]));
		byte_sx = 32'($signed(t.store_data[7:0]));
		return t.mem.store_half ? half_sx : (t.mem.store_byte ? byte_sx : t.store_data);
	endfunction

	function automatic logic [31:0] loaded_word(input ex_mem_t t, input logic [31:0] word);
		logic [31:0] half_x;
		logic [31:0] byte_x;
		half_x = t.mem.is_unsigned ? {16'd0, word[15:0]} : 32'($signed(word[15:0]));
		byte_x = t.mem.is_unsigned ? {24'd0, word[7:0]} : 32'($signed(word[7:0]));
		if (!t.mem.mem_read)
		begin
			return '0;
		end
		return t.mem.load_half ? half_x : (t.mem.load_byte ? byte_x : word);
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			mismatches++;
			$display("mismatch %s expected %h got %h at %0t", name, expected, actual, $time);
		end
	endtask

	////////////////////////////////////////
	// Prediction
	////////////////////////////////////////

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stage_in <= '0;
			expect_wb <= '0;
			expect_busy <= 1'b0;
			shadow_known <= '0;
		end
		else
		begin
			stage_in <= ex_mem_in;
			expect_wb.wb <= stage_in.wb;
			expect_wb.read_data <= loaded_word(stage_in, shadow[stage_in.alu_result[5:2]]);
			expect_wb.alu_result <= stage_in.alu_result;
			expect_wb.write_reg <= stage_in.write_reg;
			expect_wb.halt <= stage_in.halt;
			expect_busy <= (stage_in != '0);
			if (stage_in.mem.mem_write)
			begin
				shadow_known[stage_in.alu_result[5:2]] <= 1'b1;
			end
		end
	end

	// Store lands in the RAM at the same edge the load result is taken
	always @(posedge clk)
	begin
		if (!reset && stage_in.mem.mem_write)
		begin
			shadow[stage_in.alu_result[5:2]] <= stored_word(stage_in);
		end
	end

	assign expect_taken = stage_in.mem.branch &&
		(stage_in.mem.branch_ne ? !stage_in.zero : stage_in.zero);

	////////////////////////////////////////
	// Comparison on the falling edge
	////////////////////////////////////////

	always @(negedge clk)
	begin
		compare("mem_wb_out.wb", {30'd0, expect_wb.wb}, {30'd0, mem_wb_out.wb});
		compare("mem_wb_out.read_data", expect_wb.read_data, mem_wb_out.read_data);
		compare("mem_wb_out.alu_result", expect_wb.alu_result, mem_wb_out.alu_result);
		compare("mem_wb_out.write_reg", {27'd0, expect_wb.write_reg},
			{27'd0, mem_wb_out.write_reg});
		compare("mem_wb_out.halt", {31'd0, expect_wb.halt}, {31'd0, mem_wb_out.halt});
		compare("pc_src", {31'd0, expect_taken}, {31'd0, pc_src});
		compare("pc_branch", stage_in.pc_branch, pc_branch);
		// words never written have no defined value yet
		if (shadow_known[dbg_addr[5:2]])
		begin
			compare("dbg_data", shadow[dbg_addr[5:2]], dbg_data);
		end
	end

	assign busy = (stage_in != '0) || expect_busy;
	assign check_count = checks;
	assign mismatch_count = mismatches;

endmodule

`default_nettype wire

// ==== verification/mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_tb;

	import ctrl_pkg::*;
	import pipe_pkg::*;

	localparam int SEED = 33828;
	localparam int RANDOM_OPS = 400;
	localparam int DRAIN_LIMIT = 10;

	// Operation mix
	localparam int OP_IDLE = 0;
	localparam int OP_SW = 1;
	localparam int OP_SH = 2;
	localparam int OP_SB = 3;
	localparam int OP_LW = 4;
	localparam int OP_LH = 5;
	localparam int OP_LHU = 6;
	localparam int OP_LB = 7;
	localparam int OP_LBU = 8;
	localparam int OP_BEQ = 9;
	localparam int OP_BNE = 10;

	logic clk;
	logic reset;
	ex_mem_t ex_mem_in;
	logic [`DATA_W-1:0] dbg_addr;
	mem_wb_t mem_wb_out;
	logic pc_src;
	logic [`DATA_W-1:0] pc_branch;
	logic [`DATA_W-1:0] dbg_data;

	logic busy;
	int check_count;
	int mismatch_count;
	int timeouts = 0;
	logic [31:0] pick;

	mem_subsystem dut_i
	(
		.clk(clk),
		.reset(reset),
		.ex_mem_in(ex_mem_in),
		.dbg_addr(dbg_addr),
		.mem_wb_out(mem_wb_out),
		.pc_src(pc_src),
		.pc_branch(pc_branch),
		.dbg_data(dbg_data)
	);

	mem_checker chk_i
	(
		.clk(clk),
		.reset(reset),
		.ex_mem_in(ex_mem_in),
		.dbg_addr(dbg_addr),
		.mem_wb_out(mem_wb_out),
		.pc_src(pc_src),
		.pc_branch(pc_branch),
		.dbg_data(dbg_data),
		.busy(busy),
		.check_count(check_count),
		.mismatch_count(mismatch_count)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic mem_ctrl_t make_ctrl(input int op);
		mem_ctrl_t c;
		c = '0;
		c.mem_write = (op == OP_SW) || (op == OP_SH) || (op == OP_SB);
		c.mem_read = (op >= OP_LW) && (op <= OP_LBU);
		c.store_half = (op == OP_SH);
		c.store_byte = (op == OP_SB);
		c.load_half = (op == OP_LH) || (op == OP_LHU);
		c.load_byte = (op == OP_LB) || (op == OP_LBU);
		c.is_unsigned = (op == OP_LHU) || (op == OP_LBU);
		c.branch = (op == OP_BEQ) || (op == OP_BNE);
		c.branch_ne = (op == OP_BNE);
		return c;
	endfunction

	// Random payload, address kept inside words 0 to 15
	task automatic drive_op(input int op, input logic [3:0] word);
		ex_mem_t t;
		logic [31:0] r;
		logic [31:0] d;
		r = $urandom();
		d = $urandom();
		t = '0;
		t.mem = make_ctrl(op);
		t.wb = r[1:0];
		t.alu_result = (r & 32'hFFFF_E003) | {26'd0, word, 2'd0};
		t.store_data = $urandom();
		t.write_reg = r[8:4];
		t.zero = r[9];
		t.halt = r[10];
		t.pc_branch = $urandom();
		@(posedge clk);
		#2;
		ex_mem_in = t;
		dbg_addr = d & 32'hFFFF_E03F;
	endtask

	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while (busy && cycles < limit)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (busy)
		begin
			timeouts++;
			$display("timeout: pipeline still busy after %0d idle cycles", limit);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		ex_mem_in = '0;
		dbg_addr = '0;
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		// Define every shadow word first
		for (int w = 0; w < 16; w++)
		begin
			drive_op(OP_SW, w[3:0]);
		end

		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			pick = $urandom();
			drive_op($urandom_range(OP_BNE, OP_IDLE), pick[3:0]);
		end

		@(posedge clk);
		#2;
		ex_mem_in = '0;
		wait_drained(DRAIN_LIMIT);
		@(negedge clk);
		#1;

		$display("checks=%0d mismatches=%0d timeouts=%0d", check_count, mismatch_count,
			timeouts);
		if (mismatch_count == 0 && timeouts == 0 && check_count > 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/ctrl_pkg.sv ====
`default_nettype none

`include "mem_stage_defs.svh"

package ctrl_pkg;

	////////////////////////////////////////
	// Memory stage control
	////////////////////////////////////////

	// Decoded from the 9-bit memory bus of the execute stage
	typedef struct packed {
		logic mem_write;
		logic mem_read;
		// Set for both beq and bne
		logic branch;
		// Zero extension on lhu and lbu
		logic is_unsigned;
		logic load_half;
		logic load_byte;
		logic store_half;
		logic store_byte;
		// Selects bne over beq
		logic branch_ne;
	} mem_ctrl_t;

	////////////////////////////////////////
	// Write-back control
	////////////////////////////////////////

	// Carried through the memory stage untouched
	typedef struct packed {
		logic reg_write;
		// Load result instead of ALU result
		logic mem_to_reg;
	} wb_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module data_ram
(
	input wire logic clk,
	input wire logic write_en,
	input wire logic read_en,
	input wire logic [`DMEM_AW-1:0] addr,
	input wire logic [`DATA_W-1:0] write_data,
	output logic [`DATA_W-1:0] read_data,
	input wire logic [`DMEM_AW-1:0] dbg_addr,
	output logic [`DATA_W-1:0] dbg_data
);

	localparam int DEPTH = 1 << `DMEM_AW;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Contents are undefined until written
	logic [`DATA_W-1:0] mem [0:DEPTH-1];

	// Write port, full word only
	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			mem[addr] <= write_data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Asynchronous read, forced to zero when not reading
	always_comb
	begin
		if (read_en)
		begin
			read_data = mem[addr];
		end
		else
		begin
			read_data = '0;
		end
	end

	// debug port sees the array directly
	assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

// ==== verilog/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module load_store_unit
(
	input wire ctrl_pkg::mem_ctrl_t ctrl,
	input wire logic [`DATA_W-1:0] store_data,
	output logic [`DATA_W-1:0] store_word,
	input wire logic [`DATA_W-1:0] ram_word,
	output logic [`DATA_W-1:0] load_word
);

	// Extension fill bits for the narrow loads
	logic half_fill;
	logic byte_fill;

	////////////////////////////////////////
	// Store formatting
	////////////////////////////////////////

	// sh and sb still write a whole word, sign-extended
	always_comb
	begin
		if (ctrl.store_half)
		begin
			store_word = {{16{store_data[15]}}, store_data[15:0]};
		end
		else if (ctrl.store_byte)
		begin
			store_word = {{24{store_data[7]}}, store_data[7:0]};
		end
		else
		begin
			store_word = store_data;
		end
	end

	////////////////////////////////////////
	// Load extension
	////////////////////////////////////////

	// Zero fill for lhu and lbu
	assign half_fill = ctrl.is_unsigned ? 1'b0 : ram_word[15];
	assign byte_fill = ctrl.is_unsigned ? 1'b0 : ram_word[7];

	// Half has priority over byte; always the low part of the word
	always_comb
	begin
		if (ctrl.load_half)
		begin
			load_word = {{16{half_fill}}, ram_word[15:0]};
		end
		else if (ctrl.load_byte)
		begin
			load_word = {{24{byte_fill}}, ram_word[7:0]};
		end
		else
		begin
			load_word = ram_word;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_stage_defs.svh ====
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

// Data word and byte address width
`define DATA_W 32

// Register file index width
`define REG_AW 5

// Word index into the data RAM, 2048 words
`define DMEM_AW 11

`endif

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_subsystem
(
	input wire logic clk,
	input wire logic reset,
	input wire pipe_pkg::ex_mem_t ex_mem_in,
	input wire logic [`DATA_W-1:0] dbg_addr,
	output pipe_pkg::mem_wb_t mem_wb_out,
	output logic pc_src,
	output logic [`DATA_W-1:0] pc_branch,
	output logic [`DATA_W-1:0] dbg_data
);

	import pipe_pkg::*;

	ex_mem_t ex_mem_q;

	////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////

	// Loads every cycle, no stall path
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Zero control means no write and no branch
			ex_mem_q <= '0;
		end
		else
		begin
			ex_mem_q <= ex_mem_in;
		end
	end

	////////////////////////////////////////
	// Memory stage
	////////////////////////////////////////

	memory_stage stage_i
	(
		.clk(clk),
		.reset(reset),
		.ex_mem(ex_mem_q),
		.dbg_addr(dbg_addr),
		.mem_wb(mem_wb_out),
		.pc_src(pc_src),
		.pc_branch(pc_branch),
		.dbg_data(dbg_data)
	);

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module memory_stage
(
	input wire logic clk,
	input wire logic reset,
	input wire pipe_pkg::ex_mem_t ex_mem,
	input wire logic [`DATA_W-1:0] dbg_addr,
	output pipe_pkg::mem_wb_t mem_wb,
	output logic pc_src,
	output logic [`DATA_W-1:0] pc_branch,
	output logic [`DATA_W-1:0] dbg_data
);

	import pipe_pkg::*;

	// Word indices, low two address bits dropped
	logic [`DMEM_AW-1:0] ram_addr;
	logic [`DMEM_AW-1:0] ram_dbg_addr;

	logic [`DATA_W-1:0] store_word;
	logic [`DATA_W-1:0] ram_word;
	logic [`DATA_W-1:0] load_word;

	mem_wb_t mem_wb_q;

	assign ram_addr = ex_mem.alu_result[`DMEM_AW+1:2];
	assign ram_dbg_addr = dbg_addr[`DMEM_AW+1:2];

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////

	// beq takes the branch on zero, bne on nonzero
	assign pc_src = ex_mem.mem.branch & (ex_mem.zero ^ ex_mem.mem.branch_ne);
	assign pc_branch = ex_mem.pc_branch;

	////////////////////////////////////////
	// Data memory access
	////////////////////////////////////////

	load_store_unit lsu_i
	(
		.ctrl(ex_mem.mem),
		.store_data(ex_mem.store_data),
		.store_word(store_word),
		.ram_word(ram_word),
		.load_word(load_word)
	);

	data_ram ram_i
	(
		.clk(clk),
		.write_en(ex_mem.mem.mem_write),
		.read_en(ex_mem.mem.mem_read),
		.addr(ram_addr),
		.write_data(store_word),
		.read_data(ram_word),
		.dbg_addr(ram_dbg_addr),
		.dbg_data(dbg_data)
	);

	////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mem_wb_q <= '0;
		end
		else
		begin
			mem_wb_q.wb <= ex_mem.wb;
			mem_wb_q.read_data <= load_word;
			mem_wb_q.alu_result <= ex_mem.alu_result;
			mem_wb_q.write_reg <= ex_mem.write_reg;
			mem_wb_q.halt <= ex_mem.halt;
		end
	end

	assign mem_wb = mem_wb_q;

endmodule

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

`include "mem_stage_defs.svh"

package pipe_pkg;

	////////////////////////////////////////
	// EX/MEM register contents
	////////////////////////////////////////

	typedef struct packed {
		ctrl_pkg::mem_ctrl_t mem;
		ctrl_pkg::wb_ctrl_t wb;
		// Byte address for loads and stores
		logic [`DATA_W-1:0] alu_result;
		// Register value for sw, sh and sb
		logic [`DATA_W-1:0] store_data;
		logic [`REG_AW-1:0] write_reg;
		// ALU zero flag for branch resolution
		logic zero;
		logic [`DATA_W-1:0] pc_branch;
		logic halt;
	} ex_mem_t;

	////////////////////////////////////////
	// MEM/WB register contents
	////////////////////////////////////////

	typedef struct packed {
		ctrl_pkg::wb_ctrl_t wb;
		// Extended load result
		logic [`DATA_W-1:0] read_data;
		logic [`DATA_W-1:0] alu_result;
		logic [`REG_AW-1:0] write_reg;
		logic halt;
	} mem_wb_t;

endpackage

`default_nettype wire
